/* source/j4_io_pkg.sv */
package j4_io_pkg;

  localparam int WORD_W = 16;                // I/O bus word
  localparam int PIN_W  = 8;                 // Pins per port
  localparam int MISC_W = 3;                 // Misc out and misc in
  localparam int SLOT_N = 4;                 // Hardware threads

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [PIN_W-1:0]  pin_t;
  typedef logic [SLOT_N-1:0] slot_mask_t;    // One bit per thread
  typedef logic [MISC_W-1:0] misc_t;

  // Running thread, gray code in rotation order 0,1,3,2
  typedef enum logic [1:0] {
    SLOT0 = 2'd0,
    SLOT1 = 2'd1,
    SLOT3 = 2'd3,
    SLOT2 = 2'd2
  } thread_e;

  // Address bit of each register, one-hot address selects it
  typedef enum logic [3:0] {
    PMOD_IO    = 4'd0,                       // Pin data / pin input
    PMOD_DIR   = 4'd1,                       // 1 is output
    LEDS       = 4'd2,
    MISC_OUT   = 4'd3,
    HDR1_IO    = 4'd4,
    HDR1_DIR   = 4'd5,
    HDR2_IO    = 4'd6,
    HDR2_DIR   = 4'd7,
    TASK1      = 4'd8,                       // Exec token / timer or lap
    TASK2      = 4'd9,
    TASK3      = 4'd10,
    STATUS     = 4'd13,                      // External misc inputs
    TASK_FETCH = 4'd14,                      // Exec fetch, kill request on write
    THREAD_ID  = 4'd15
  } io_bit_e;

  // Task block values seen by the read mux
  typedef struct packed {
    word_t [3:1] slot_rd;                    // Lap for slot 0, timer for others
    word_t       exec;                       // Token of the running thread
  } task_rd_t;

endpackage

/* source/io_bus_if.sv */
// Registered I/O bus, one cycle behind the CPU strobes
interface io_bus_if;

  logic                 rd;                  // Read strobe
  logic                 wr;                  // Write strobe
  j4_io_pkg::word_t     addr;                // Held between accesses
  j4_io_pkg::word_t     wdata;
  j4_io_pkg::thread_e   thread;              // Thread of this cycle

  modport stage (
    output rd,
    output wr,
    output addr,
    output wdata,
    output thread
  );

  modport sink (
    input rd,
    input wr,
    input addr,
    input wdata,
    input thread
  );

  // Read-back only needs select and thread
  modport mux (
    input addr,
    input thread
  );

endinterface

/* source/gpio_rd_if.sv */
// Port state for read-back
interface gpio_rd_if;

  j4_io_pkg::pin_t  pmod_in;                 // Pin inputs
  j4_io_pkg::pin_t  hdr1_in;
  j4_io_pkg::pin_t  hdr2_in;
  j4_io_pkg::pin_t  pmod_dir;                // Direction registers
  j4_io_pkg::pin_t  hdr1_dir;
  j4_io_pkg::pin_t  hdr2_dir;
  j4_io_pkg::pin_t  leds;
  j4_io_pkg::misc_t misc_out;

  modport bank (
    output pmod_in, hdr1_in, hdr2_in,
    output pmod_dir, hdr1_dir, hdr2_dir,
    output leds, misc_out
  );

  modport mux (
    input pmod_in, hdr1_in, hdr2_in,
    input pmod_dir, hdr1_dir, hdr2_dir,
    input leds, misc_out
  );

endinterface

/* source/io_bus_stage.sv */
module io_bus_stage (
  input  logic               clk,
  input  logic               resetq,
  input  logic               io_rd,          // One-cycle CPU strobes
  input  logic               io_wr,
  input  j4_io_pkg::word_t   io_addr,
  input  j4_io_pkg::word_t   io_wdata,
  input  j4_io_pkg::thread_e io_thread,
  io_bus_if.stage            bus
);

  logic access;

  assign access = io_rd | io_wr;             // Any strobe

  // Strobes are the only control state here
  always_ff @(posedge clk) begin
    if (!resetq) begin
      bus.rd <= 1'b0;
      bus.wr <= 1'b0;
    end else begin
      bus.rd <= io_rd;
      bus.wr <= io_wr;
    end
  end

  // Data and thread follow every cycle
  always_ff @(posedge clk) begin
    bus.wdata  <= io_wdata;
    bus.thread <= io_thread;                 // Same edge as the address
    if (access) begin
      bus.addr <= io_addr;                   // Held until the next access
    end
  end

endmodule

/* source/gpio_bank.sv */
module gpio_bank #(
  parameter int PIN_W = j4_io_pkg::PIN_W
) (
  input  logic              clk,
  input  logic              resetq,
  io_bus_if.sink            bus,
  input  j4_io_pkg::pin_t   pmod_in,         // Pad inputs
  input  j4_io_pkg::pin_t   hdr1_in,
  input  j4_io_pkg::pin_t   hdr2_in,
  output j4_io_pkg::pin_t   pmod_out,        // Registered pad outputs
  output j4_io_pkg::pin_t   pmod_oe,
  output j4_io_pkg::pin_t   hdr1_out,
  output j4_io_pkg::pin_t   hdr1_oe,
  output j4_io_pkg::pin_t   hdr2_out,
  output j4_io_pkg::pin_t   hdr2_oe,
  output j4_io_pkg::pin_t   leds,
  output j4_io_pkg::misc_t  misc_out,
  gpio_rd_if.bank           rd
);

  localparam int PORT_N = 3;                 // PMOD, HDR1, HDR2

  localparam j4_io_pkg::io_bit_e IO_BIT [PORT_N] =
    '{j4_io_pkg::PMOD_IO, j4_io_pkg::HDR1_IO, j4_io_pkg::HDR2_IO};
  localparam j4_io_pkg::io_bit_e DIR_BIT [PORT_N] =
    '{j4_io_pkg::PMOD_DIR, j4_io_pkg::HDR1_DIR, j4_io_pkg::HDR2_DIR};

  j4_io_pkg::pin_t  port_q [PORT_N];         // Pin data registers
  j4_io_pkg::pin_t  dir_q  [PORT_N];         // 1 drives the pin
  j4_io_pkg::pin_t  leds_q;
  j4_io_pkg::misc_t misc_q;
  j4_io_pkg::pin_t  wbyte;

  assign wbyte = bus.wdata[PIN_W-1:0];       // Ports take the low byte

  // Pin data only reaches a pad through its enable
  always_ff @(posedge clk) begin
    for (int p = 0; p < PORT_N; p++) begin
      if (bus.wr && bus.addr[IO_BIT[p]]) begin
        port_q[p] <= wbyte;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int p = 0; p < PORT_N; p++) begin
        dir_q[p] <= '0;                      // All pins input
      end
      leds_q <= '0;
      misc_q <= '0;
    end else begin
      for (int p = 0; p < PORT_N; p++) begin
        if (bus.wr && bus.addr[DIR_BIT[p]]) begin
          dir_q[p] <= wbyte;
        end
      end
      if (bus.wr && bus.addr[j4_io_pkg::LEDS]) begin
        leds_q <= wbyte;
      end
      if (bus.wr && bus.addr[j4_io_pkg::MISC_OUT]) begin
        misc_q <= bus.wdata[j4_io_pkg::MISC_W-1:0];
      end
    end
  end

  assign pmod_out = port_q[0];
  assign pmod_oe  = dir_q[0];                // Enable is the direction bit
  assign hdr1_out = port_q[1];
  assign hdr1_oe  = dir_q[1];
  assign hdr2_out = port_q[2];
  assign hdr2_oe  = dir_q[2];
  assign leds     = leds_q;
  assign misc_out = misc_q;

  // IO bits read the pads, not the data registers
  assign rd.pmod_in  = pmod_in;
  assign rd.hdr1_in  = hdr1_in;
  assign rd.hdr2_in  = hdr2_in;
  assign rd.pmod_dir = dir_q[0];
  assign rd.hdr1_dir = dir_q[1];
  assign rd.hdr2_dir = dir_q[2];
  assign rd.leds     = leds_q;
  assign rd.misc_out = misc_q;

endmodule

/* source/task_slots.sv */
module task_slots (
  input  logic                  clk,
  input  logic                  resetq,
  io_bus_if.sink                bus,
  output j4_io_pkg::task_rd_t   task_rd,
  output j4_io_pkg::slot_mask_t kill_slot_rq
);

  localparam int TASK_BASE = int'(j4_io_pkg::TASK1);   // TASKn is bit TASK_BASE+n-1

  // Timer n advances on accesses from this thread, staggered around the rotation
  localparam j4_io_pkg::thread_e CNT_THREAD [1:3] =
    '{j4_io_pkg::SLOT3, j4_io_pkg::SLOT2, j4_io_pkg::SLOT1};

  j4_io_pkg::word_t       exec_tok [1:3];    // Task exec tokens
  j4_io_pkg::word_t       timer    [1:3];    // Accesses since last fetch
  j4_io_pkg::word_t       lap      [1:3];    // Timer at last fetch
  j4_io_pkg::word_t [3:1] slot_live;
  j4_io_pkg::word_t [3:1] slot_hold;
  logic                   bus_act;
  logic                   is_slot0;
  logic                   fetch_rd;
  logic                   fetch_wr;

  assign bus_act  = bus.rd | bus.wr;
  assign is_slot0 = (bus.thread == j4_io_pkg::SLOT0);
  assign fetch_rd = bus.rd & bus.addr[j4_io_pkg::TASK_FETCH];
  assign fetch_wr = bus.wr & bus.addr[j4_io_pkg::TASK_FETCH];

  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int n = 1; n <= 3; n++) begin
        exec_tok[n] <= '0;
        timer[n]    <= '0;
        lap[n]      <= '0;
      end
    end else begin
      for (int n = 1; n <= 3; n++) begin
        // Any slot may assign a task
        if (bus.wr && bus.addr[TASK_BASE + n - 1]) begin
          exec_tok[n] <= bus.wdata;
        end
        if (fetch_rd && bus.thread == 2'(n)) begin
          lap[n]   <= timer[n];              // Slot n fetched its next task
          timer[n] <= '0;
        end else begin
          if (bus_act && bus.thread == CNT_THREAD[n]) begin
            timer[n] <= timer[n] + 1'b1;
          end
          // Slot 0 poll consumes the lap
          if (bus.rd && is_slot0 && bus.addr[TASK_BASE + n - 1]) begin
            lap[n] <= '0;
          end
        end
      end
    end
  end

  // Own bit for a worker slot, any mask for slot 0
  always_ff @(posedge clk) begin
    if (!resetq) begin
      kill_slot_rq <= '0;
    end else if (!fetch_wr) begin
      kill_slot_rq <= '0;                    // One-cycle request
    end else if (is_slot0) begin
      kill_slot_rq <= bus.wdata[j4_io_pkg::SLOT_N-1:0];
    end else begin
      kill_slot_rq <= j4_io_pkg::slot_mask_t'(1) << bus.thread;
    end
  end

  always_comb begin
    for (int n = 1; n <= 3; n++) begin
      slot_live[n] = is_slot0 ? lap[n] : timer[n];
    end
  end

  // Value frozen after the access cycle, the read's own lap clear
  // or timer step must not change the returned word
  always_ff @(posedge clk) begin
    if (bus_act) begin
      slot_hold <= slot_live;
    end
  end

  always_comb begin
    task_rd.slot_rd = bus_act ? slot_live : slot_hold;
    case (bus.thread)
      j4_io_pkg::SLOT1: task_rd.exec = exec_tok[1];
      j4_io_pkg::SLOT2: task_rd.exec = exec_tok[2];
      j4_io_pkg::SLOT3: task_rd.exec = exec_tok[3];
      default:          task_rd.exec = '0;  // Slot 0 always runs quit
    endcase
  end

endmodule

/* source/io_read_mux.sv */
module io_read_mux #(
  parameter int PIN_W = j4_io_pkg::PIN_W
) (
  io_bus_if.mux                bus,
  gpio_rd_if.mux               gpio,
  input  j4_io_pkg::task_rd_t  task_rd,
  input  j4_io_pkg::misc_t     misc_in,      // External status inputs
  output j4_io_pkg::word_t     io_rdata
);

  // Port value widened to a bus word
  function automatic j4_io_pkg::word_t pin_ext(input j4_io_pkg::pin_t p);
    return {{(j4_io_pkg::WORD_W - PIN_W){1'b0}}, p[PIN_W-1:0]};
  endfunction

  function automatic j4_io_pkg::word_t misc_ext(input j4_io_pkg::misc_t m);
    return {{(j4_io_pkg::WORD_W - j4_io_pkg::MISC_W){1'b0}}, m};
  endfunction

  // OR of every selected source, address is one-hot in use
  always_comb begin
    io_rdata = '0;
    if (bus.addr[j4_io_pkg::PMOD_IO])    io_rdata |= pin_ext(gpio.pmod_in);
    if (bus.addr[j4_io_pkg::PMOD_DIR])   io_rdata |= pin_ext(gpio.pmod_dir);
    if (bus.addr[j4_io_pkg::LEDS])       io_rdata |= pin_ext(gpio.leds);
    if (bus.addr[j4_io_pkg::MISC_OUT])   io_rdata |= misc_ext(gpio.misc_out);
    if (bus.addr[j4_io_pkg::HDR1_IO])    io_rdata |= pin_ext(gpio.hdr1_in);
    if (bus.addr[j4_io_pkg::HDR1_DIR])   io_rdata |= pin_ext(gpio.hdr1_dir);
    if (bus.addr[j4_io_pkg::HDR2_IO])    io_rdata |= pin_ext(gpio.hdr2_in);
    if (bus.addr[j4_io_pkg::HDR2_DIR])   io_rdata |= pin_ext(gpio.hdr2_dir);
    if (bus.addr[j4_io_pkg::TASK1])      io_rdata |= task_rd.slot_rd[1];
    if (bus.addr[j4_io_pkg::TASK2])      io_rdata |= task_rd.slot_rd[2];
    if (bus.addr[j4_io_pkg::TASK3])      io_rdata |= task_rd.slot_rd[3];
    if (bus.addr[j4_io_pkg::STATUS])     io_rdata |= misc_ext(misc_in);
    if (bus.addr[j4_io_pkg::TASK_FETCH]) io_rdata |= task_rd.exec;
    if (bus.addr[j4_io_pkg::THREAD_ID])  io_rdata |= j4_io_pkg::word_t'(bus.thread);
  end

endmodule

/* source/j4_io_top.sv */
module j4_io_top #(
  parameter int PIN_W = j4_io_pkg::PIN_W
) (
  input  logic                  clk,
  input  logic                  resetq,
  input  logic                  io_rd,       // CPU I/O strobes
  input  logic                  io_wr,
  input  j4_io_pkg::word_t      io_addr,
  input  j4_io_pkg::word_t      io_wdata,
  input  j4_io_pkg::thread_e    io_thread,   // Running thread
  output j4_io_pkg::word_t      io_rdata,
  input  j4_io_pkg::pin_t       pmod_in,
  output j4_io_pkg::pin_t       pmod_out,
  output j4_io_pkg::pin_t       pmod_oe,
  input  j4_io_pkg::pin_t       hdr1_in,
  output j4_io_pkg::pin_t       hdr1_out,
  output j4_io_pkg::pin_t       hdr1_oe,
  input  j4_io_pkg::pin_t       hdr2_in,
  output j4_io_pkg::pin_t       hdr2_out,
  output j4_io_pkg::pin_t       hdr2_oe,
  output j4_io_pkg::pin_t       leds,
  output j4_io_pkg::misc_t      misc_out,
  input  j4_io_pkg::misc_t      misc_in,
  output j4_io_pkg::slot_mask_t kill_slot_rq  // Slot reboot requests
);

  io_bus_if  bus_if ();
  gpio_rd_if gpio_if ();

  j4_io_pkg::task_rd_t task_rd;

  io_bus_stage u_stage (
    .clk       (clk),
    .resetq    (resetq),
    .io_rd     (io_rd),
    .io_wr     (io_wr),
    .io_addr   (io_addr),
    .io_wdata  (io_wdata),
    .io_thread (io_thread),
    .bus       (bus_if.stage)
  );

  gpio_bank #(.PIN_W(PIN_W)) u_gpio (
    .clk      (clk),
    .resetq   (resetq),
    .bus      (bus_if.sink),
    .pmod_in  (pmod_in),
    .hdr1_in  (hdr1_in),
    .hdr2_in  (hdr2_in),
    .pmod_out (pmod_out),
    .pmod_oe  (pmod_oe),
    .hdr1_out (hdr1_out),
    .hdr1_oe  (hdr1_oe),
    .hdr2_out (hdr2_out),
    .hdr2_oe  (hdr2_oe),
    .leds     (leds),
    .misc_out (misc_out),
    .rd       (gpio_if.bank)
  );

  task_slots u_task (
    .clk          (clk),
    .resetq       (resetq),
    .bus          (bus_if.sink),
    .task_rd      (task_rd),
    .kill_slot_rq (kill_slot_rq)
  );

  io_read_mux #(.PIN_W(PIN_W)) u_rmux (
    .bus      (bus_if.mux),
    .gpio     (gpio_if.mux),
    .task_rd  (task_rd),
    .misc_in  (misc_in),
    .io_rdata (io_rdata)
  );

endmodule

/* verification/j4_io_cases.svh */
`ifndef J4_IO_CASES_SVH
`define J4_IO_CASES_SVH

  localparam int CASE_N = 36;

  // Columns are kind, thread, address bit, write data, pin inputs,
  // expected read word, expected port output and expected kill mask
  localparam row_t CASES [CASE_N] = '{
    '{ACC_WR, j4_io_pkg::SLOT0, j4_io_pkg::PMOD_IO,    16'h00a5, 8'h00, 16'h0000, 8'ha5, 4'h0},
    '{ACC_WR, j4_io_pkg::SLOT0, j4_io_pkg::PMOD_DIR,   16'h003c, 8'h00, 16'h0000, 8'h3c, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT0, j4_io_pkg::PMOD_DIR,   16'h0000, 8'h00, 16'h003c, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT0, j4_io_pkg::PMOD_IO,    16'h0000, 8'h5c, 16'h005c, 8'h00, 4'h0},
    '{ACC_WR, j4_io_pkg::SLOT0, j4_io_pkg::HDR1_IO,    16'h1234, 8'h00, 16'h0000, 8'h34, 4'h0},
    '{ACC_WR, j4_io_pkg::SLOT0, j4_io_pkg::HDR1_DIR,   16'h00c3, 8'h00, 16'h0000, 8'hc3, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT0, j4_io_pkg::HDR1_DIR,   16'h0000, 8'h00, 16'h00c3, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT0, j4_io_pkg::HDR1_IO,    16'h0000, 8'h0c, 16'h00f3, 8'h00, 4'h0},
    '{ACC_WR, j4_io_pkg::SLOT0, j4_io_pkg::HDR2_IO,    16'h0066, 8'h00, 16'h0000, 8'h66, 4'h0},
    '{ACC_WR, j4_io_pkg::SLOT0, j4_io_pkg::HDR2_DIR,   16'h0081, 8'h00, 16'h0000, 8'h81, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT0, j4_io_pkg::HDR2_DIR,   16'h0000, 8'h00, 16'h0081, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT0, j4_io_pkg::HDR2_IO,    16'h0000, 8'h12, 16'h0021, 8'h00, 4'h0},
    // LEDs, misc out, status
    '{ACC_WR, j4_io_pkg::SLOT0, j4_io_pkg::LEDS,       16'h00b7, 8'h00, 16'h0000, 8'hb7, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT0, j4_io_pkg::LEDS,       16'h0000, 8'h00, 16'h00b7, 8'h00, 4'h0},
    '{ACC_WR, j4_io_pkg::SLOT0, j4_io_pkg::MISC_OUT,   16'h0005, 8'h00, 16'h0000, 8'h05, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT0, j4_io_pkg::MISC_OUT,   16'h0000, 8'h00, 16'h0005, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT0, j4_io_pkg::STATUS,     16'h0000, 8'h06, 16'h0006, 8'h00, 4'h0},
    // Exec token for task 2
    '{ACC_WR, j4_io_pkg::SLOT1, j4_io_pkg::TASK2,      16'hbeef, 8'h00, 16'h0000, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT2, j4_io_pkg::TASK_FETCH, 16'h0000, 8'h00, 16'hbeef, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT0, j4_io_pkg::TASK_FETCH, 16'h0000, 8'h00, 16'h0000, 8'h00, 4'h0},
    // Thread ID reads with SLOT3 access 1
    '{ACC_RD, j4_io_pkg::SLOT0, j4_io_pkg::THREAD_ID,  16'h0000, 8'h00, 16'h0000, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT1, j4_io_pkg::THREAD_ID,  16'h0000, 8'h00, 16'h0001, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT3, j4_io_pkg::THREAD_ID,  16'h0000, 8'h00, 16'h0003, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT2, j4_io_pkg::THREAD_ID,  16'h0000, 8'h00, 16'h0002, 8'h00, 4'h0},
    // Kill requests with SLOT3 access 2
    '{ACC_WR, j4_io_pkg::SLOT0, j4_io_pkg::TASK_FETCH, 16'h000a, 8'h00, 16'h0000, 8'h00, 4'ha},
    '{ACC_WR, j4_io_pkg::SLOT3, j4_io_pkg::TASK_FETCH, 16'h0000, 8'h00, 16'h0000, 8'h00, 4'h8},
    '{ACC_RD, j4_io_pkg::SLOT0, j4_io_pkg::LEDS,       16'h0000, 8'h00, 16'h00b7, 8'h00, 4'h0},
    // Rotation with SLOT3 accesses 3 and 4
    '{ACC_RD, j4_io_pkg::SLOT1, j4_io_pkg::THREAD_ID,  16'h0000, 8'h00, 16'h0001, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT3, j4_io_pkg::THREAD_ID,  16'h0000, 8'h00, 16'h0003, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT2, j4_io_pkg::THREAD_ID,  16'h0000, 8'h00, 16'h0002, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT0, j4_io_pkg::THREAD_ID,  16'h0000, 8'h00, 16'h0000, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT3, j4_io_pkg::TASK1,      16'h0000, 8'h00, 16'h0003, 8'h00, 4'h0},
    // Fetch by SLOT1 moves timer 1 into lap 1
    '{ACC_RD, j4_io_pkg::SLOT1, j4_io_pkg::TASK_FETCH, 16'h0000, 8'h00, 16'h0000, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT1, j4_io_pkg::TASK1,      16'h0000, 8'h00, 16'h0000, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT0, j4_io_pkg::TASK1,      16'h0000, 8'h00, 16'h0004, 8'h00, 4'h0},
    '{ACC_RD, j4_io_pkg::SLOT0, j4_io_pkg::TASK1,      16'h0000, 8'h00, 16'h0000, 8'h00, 4'h0}
  };

`endif

/* verification/j4_io_tb.sv */
module j4_io_tb;

  typedef enum logic {ACC_RD, ACC_WR} acc_e;

  // One bus access and its expected results
  typedef struct packed {
    acc_e                  kind;
    j4_io_pkg::thread_e    thread;
    j4_io_pkg::io_bit_e    reg_bit;          // Address bit of the access
    j4_io_pkg::word_t      wdata;
    j4_io_pkg::pin_t       pins;             // Pad inputs during the access
    j4_io_pkg::word_t      exp_word;         // Read rows only
    j4_io_pkg::pin_t       exp_pins;         // Port writes only
    j4_io_pkg::slot_mask_t exp_kill;
  } row_t;

  `include "j4_io_cases.svh"

  localparam int CYCLE_LIMIT = CASE_N * 4 + 20;

  logic                  clk;
  logic                  resetq;
  logic                  io_rd;
  logic                  io_wr;
  j4_io_pkg::word_t      io_addr;
  j4_io_pkg::word_t      io_wdata;
  j4_io_pkg::thread_e    io_thread;
  j4_io_pkg::word_t      io_rdata;
  j4_io_pkg::pin_t       pmod_in;
  j4_io_pkg::pin_t       pmod_out;
  j4_io_pkg::pin_t       pmod_oe;
  j4_io_pkg::pin_t       hdr1_in;
  j4_io_pkg::pin_t       hdr1_out;
  j4_io_pkg::pin_t       hdr1_oe;
  j4_io_pkg::pin_t       hdr2_in;
  j4_io_pkg::pin_t       hdr2_out;
  j4_io_pkg::pin_t       hdr2_oe;
  j4_io_pkg::pin_t       leds;
  j4_io_pkg::misc_t      misc_out;
  j4_io_pkg::misc_t      misc_in;
  j4_io_pkg::slot_mask_t kill_slot_rq;

  int checks = 0;
  int errors = 0;
  int cycles = 0;

  j4_io_top #(.PIN_W(8)) dut0 (.*);

  always #5 clk = ~clk;                      // Period 10

  // Run guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout, the table did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input j4_io_pkg::word_t got,
                            input j4_io_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_pins(input string name, input j4_io_pkg::pin_t got,
                            input j4_io_pkg::pin_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_kill(input j4_io_pkg::slot_mask_t got,
                            input j4_io_pkg::slot_mask_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch kill_slot_rq: got %h, expected %h", got, exp);
    end
  endtask

  // Each port sees its own pattern so a wrong select shows up
  task automatic drive_pins(input j4_io_pkg::pin_t p);
    pmod_in = p;
    hdr1_in = ~p;
    hdr2_in = {p[3:0], p[7:4]};              // Nibbles swapped
    misc_in = p[2:0];
  endtask

  // Output that a register write must reach
  task automatic inspect_port_output(input row_t r);
    case (r.reg_bit)
      j4_io_pkg::PMOD_IO:  check_pins("pmod_out", pmod_out, r.exp_pins);
      j4_io_pkg::PMOD_DIR: check_pins("pmod_oe", pmod_oe, r.exp_pins);
      j4_io_pkg::HDR1_IO:  check_pins("hdr1_out", hdr1_out, r.exp_pins);
      j4_io_pkg::HDR1_DIR: check_pins("hdr1_oe", hdr1_oe, r.exp_pins);
      j4_io_pkg::HDR2_IO:  check_pins("hdr2_out", hdr2_out, r.exp_pins);
      j4_io_pkg::HDR2_DIR: check_pins("hdr2_oe", hdr2_oe, r.exp_pins);
      j4_io_pkg::LEDS:     check_pins("leds", leds, r.exp_pins);
      j4_io_pkg::MISC_OUT: check_pins("misc_out", j4_io_pkg::pin_t'(misc_out), r.exp_pins);
      default: ;                             // Task writes only show as kill
    endcase
  endtask

  initial begin
    row_t row;
    int   errs_at_start;
    clk       = 1'b0;
    resetq    = 1'b0;
    io_rd     = 1'b0;
    io_wr     = 1'b0;
    io_addr   = '0;
    io_wdata  = '0;
    io_thread = j4_io_pkg::SLOT0;
    drive_pins('0);

    repeat (3) @(posedge clk);               // Reset for 3 cycles
    @(negedge clk);
    resetq = 1'b1;
    @(negedge clk);

    errs_at_start = errors;
    check_pins("pmod_oe", pmod_oe, '0);      // All pins input after reset
    check_pins("hdr1_oe", hdr1_oe, '0);
    check_pins("hdr2_oe", hdr2_oe, '0);
    check_kill(kill_slot_rq, '0);
    $display("Reset values: %s", (errors == errs_at_start) ? "ok" : "FAILED");

    for (int i = 0; i < CASE_N; i++) begin
      row           = CASES[i];
      errs_at_start = errors;
      io_addr       = j4_io_pkg::word_t'(1) << row.reg_bit;   // One-hot select
      io_wdata      = row.wdata;
      io_thread     = row.thread;            // Held until the sample
      drive_pins(row.pins);
      io_rd         = (row.kind == ACC_RD);
      io_wr         = (row.kind == ACC_WR);
      @(negedge clk);
      io_rd = 1'b0;                          // One-cycle strobe
      io_wr = 1'b0;
      @(negedge clk);                        // Write and kill settled, read held
      if (row.kind == ACC_RD) begin
        check_word("io_rdata", io_rdata, row.exp_word);
      end else begin
        inspect_port_output(row);
      end
      check_kill(kill_slot_rq, row.exp_kill);
      $display("Row %0d %s %s from %s: %s", i, row.kind.name(), row.reg_bit.name(),
               row.thread.name(), (errors == errs_at_start) ? "ok" : "FAILED");
    end

    $display("Rows %0d, checks %0d, errors %0d", CASE_N, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+verification
source/j4_io_pkg.sv
source/io_bus_if.sv
source/gpio_rd_if.sv
source/io_bus_stage.sv
source/gpio_bank.sv
source/task_slots.sv
source/io_read_mux.sv
source/j4_io_top.sv
verification/j4_io_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench and the RTL with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module j4_io_tb -f flist.f

out=$(./obj_dir/Vj4_io_tb)
echo "$out"

# Nonzero exit when the pass line is missing
echo "$out" | grep -qx "Simulation passed"
